// File: src/cache_geom_pkg.sv
`default_nettype none

package cache_geom_pkg;

    // ==============================
    // Geometry
    // ==============================
    localparam int ADDR_W         = 32;
    localparam int WORD_W         = 32;
    localparam int WORDS_PER_LINE = 8;
    localparam int LINE_W         = WORDS_PER_LINE * WORD_W;   // 256 bits
    localparam int N_SETS         = 16;                        // Sets per way

    localparam int BYTE_BITS = 2;
    localparam int WORD_BITS = $clog2(WORDS_PER_LINE);
    localparam int SET_BITS  = $clog2(N_SETS);
    localparam int TAG_BITS  = ADDR_W - SET_BITS - WORD_BITS - BYTE_BITS;

    localparam int LINE_OFF_W  = WORD_BITS + BYTE_BITS;        // Byte offset inside a line
    localparam int LINE_ADDR_W = ADDR_W - LINE_OFF_W;

    // ==============================
    // Basic types
    // ==============================
    typedef logic [WORD_W-1:0]        word_t;
    typedef logic [LINE_W-1:0]        line_t;     // Word 0 in the top bits
    typedef logic [WORD_W/8-1:0]      byte_en_t;  // Bit n -> byte n
    typedef logic [TAG_BITS-1:0]      tag_t;
    typedef logic [SET_BITS-1:0]      set_idx_t;
    typedef logic [WORD_BITS-1:0]     word_idx_t;

    // Lookup view of an address
    typedef struct packed {
        tag_t                 tag;
        set_idx_t             set;
        word_idx_t            word;
        logic [BYTE_BITS-1:0] byte_off;
    } addr_fields_t;

    // Memory view of an address
    typedef struct packed {
        logic [LINE_ADDR_W-1:0] line_addr;
        logic [LINE_OFF_W-1:0]  offset;
    } addr_line_t;

    typedef union packed {
        addr_fields_t f;
        addr_line_t   l;
    } cache_addr_u;

endpackage

`default_nettype wire

// File: src/cache_ctrl_pkg.sv
`default_nettype none

package cache_ctrl_pkg;

    // ==============================
    // Controller states
    // ==============================
    typedef enum logic [2:0] {
        ST_IDLE      = 3'd0,   // Waiting for a request
        ST_LOOKUP    = 3'd1,   // Tag compare on registered arrays
        ST_WB        = 3'd2,   // Dirty victim to memory
        ST_WB_DONE   = 3'd3,
        ST_FILL      = 3'd4,   // Line fetch from memory
        ST_FILL_DONE = 3'd5    // Line into the arrays
    } ctrl_state_e;

    // ==============================
    // Request bundles
    // ==============================
    // 69-bit processor request
    typedef struct packed {
        logic                        rw;        // 1 = write
        cache_geom_pkg::byte_en_t    byte_en;
        cache_geom_pkg::cache_addr_u addr;
        cache_geom_pkg::word_t       wdata;
    } cpu_req_t;

    // 290-bit memory request
    typedef struct packed {
        logic                                strobe;
        logic                                rw;    // 1 = write-back
        logic [cache_geom_pkg::ADDR_W-1:0]   addr;  // Line aligned
        cache_geom_pkg::line_t               wdata;
    } mem_req_t;

endpackage

`default_nettype wire

// File: src/line_merge.sv
`timescale 1ns/1ps
`default_nettype none

module line_merge
(
    input  cache_geom_pkg::line_t     line_i,
    input  cache_geom_pkg::word_idx_t word_idx_i,
    input  cache_geom_pkg::byte_en_t  byte_en_i,
    input  cache_geom_pkg::word_t     wdata_i,
    output cache_geom_pkg::word_t     rword_o,
    output cache_geom_pkg::line_t     line_o
);
    import cache_geom_pkg::*;

    word_t new_word;   // Addressed word after byte insertion

    // Word select with word 0 at the top
    always_comb
    begin
        rword_o = '0;
        for (int w = 0; w < WORDS_PER_LINE; w++)
        begin
            if (word_idx_t'(w) == word_idx_i)
                rword_o = line_i[LINE_W-1-w*WORD_W -: WORD_W];
        end
    end

    // Any mask of byte enables
    always_comb
    begin
        new_word = rword_o;
        for (int b = 0; b < $bits(byte_en_t); b++)
        begin
            if (byte_en_i[b])
                new_word[b*8 +: 8] = wdata_i[b*8 +: 8];
        end
    end

    // Other words pass unchanged
    always_comb
    begin
        line_o = line_i;
        for (int w = 0; w < WORDS_PER_LINE; w++)
        begin
            if (word_idx_t'(w) == word_idx_i)
                line_o[LINE_W-1-w*WORD_W -: WORD_W] = new_word;
        end
    end

endmodule

`default_nettype wire

// File: src/way_store.sv
`timescale 1ns/1ps
`default_nettype none

module way_store
#(
    parameter int  N_WAYS = 4,
    localparam int WAY_W  = $clog2(N_WAYS)
)
(
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  cache_geom_pkg::set_idx_t  set_i,
    input  cache_geom_pkg::tag_t      tag_i,
    input  logic [N_WAYS-1:0]         wr_way_i,
    input  cache_geom_pkg::line_t     wr_line_i,
    input  logic                      valid_set_i,
    input  logic                      dirty_set_i,
    input  logic                      dirty_clr_i,
    input  logic [WAY_W-1:0]          victim_way_i,
    output logic [N_WAYS-1:0]         hit_way_o,
    output cache_geom_pkg::line_t     hit_line_o,
    output cache_geom_pkg::tag_t      victim_tag_o,
    output cache_geom_pkg::line_t     victim_line_o,
    output logic                      victim_dirty_o
);
    import cache_geom_pkg::*;

    logic [N_WAYS-1:0] valid_q [N_SETS];
    logic [N_WAYS-1:0] dirty_q [N_SETS];
    set_idx_t          set_q;            // Set of the registered read
    tag_t              tag_rd  [N_WAYS];
    line_t             line_rd [N_WAYS];

    // ==============================
    // Tag and data arrays
    // ==============================
    for (genvar w = 0; w < N_WAYS; w++)
    begin : g_way
        tag_t  tag_mem  [N_SETS];
        line_t line_mem [N_SETS];

        always_ff @(posedge clk_i)
        begin
            if (wr_way_i[w])
            begin
                tag_mem[set_i]  <= tag_i;
                line_mem[set_i] <= wr_line_i;
                tag_rd[w]       <= tag_i;       // Write-first read port
                line_rd[w]      <= wr_line_i;
            end
            else
            begin
                tag_rd[w]  <= tag_mem[set_i];
                line_rd[w] <= line_mem[set_i];
            end
        end

        // Parallel compare
        assign hit_way_o[w] = valid_q[set_q][w] && (tag_rd[w] == tag_i);
    end

    always_ff @(posedge clk_i)
    begin
        set_q <= set_i;
    end

    // ==============================
    // Valid and dirty bits
    // ==============================
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            for (int s = 0; s < N_SETS; s++)
            begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
        end
        else
        begin
            if (valid_set_i)
                valid_q[set_i] <= valid_q[set_i] | wr_way_i;
            if (dirty_set_i)
                dirty_q[set_i] <= dirty_q[set_i] | wr_way_i;   // Hit way or refilled way
            else if (dirty_clr_i)
                dirty_q[set_i][victim_way_i] <= 1'b0;
        end
    end

    // Hit line as the OR of at most one way
    always_comb
    begin
        hit_line_o = '0;
        for (int w = 0; w < N_WAYS; w++)
        begin
            if (hit_way_o[w])
                hit_line_o = hit_line_o | line_rd[w];
        end
    end

    // Victim readout
    assign victim_tag_o   = tag_rd[victim_way_i];
    assign victim_line_o  = line_rd[victim_way_i];
    assign victim_dirty_o = dirty_q[set_q][victim_way_i];

    // A tag lives in at most one way of a set
    a_hit_onehot: assert property (@(posedge clk_i) disable iff (rst_i)
        $onehot0(hit_way_o));

endmodule

`default_nettype wire

// File: src/dcache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl
#(
    parameter int  N_WAYS = 4,
    localparam int WAY_W  = $clog2(N_WAYS)
)
(
    input  logic                       clk_i,
    input  logic                       rst_i,
    // Processor
    input  logic                       p_req_i,
    input  cache_ctrl_pkg::cpu_req_t   p_cpu_req_i,
    output cache_geom_pkg::word_t      p_rdata_o,
    output logic                       p_ready_o,
    // Memory
    output cache_ctrl_pkg::mem_req_t   m_req_o,
    input  cache_geom_pkg::line_t      m_rdata_i,
    input  logic                       m_ready_i,
    // Way store
    output cache_geom_pkg::set_idx_t   set_o,
    output cache_geom_pkg::tag_t       tag_o,
    output logic [N_WAYS-1:0]          wr_way_o,
    output cache_geom_pkg::line_t      wr_line_o,
    output logic                       valid_set_o,
    output logic                       dirty_set_o,
    output logic                       dirty_clr_o,
    output logic [WAY_W-1:0]           victim_way_o,
    input  logic [N_WAYS-1:0]          hit_way_i,
    input  cache_geom_pkg::line_t      hit_line_i,
    input  cache_geom_pkg::line_t      victim_line_i,
    input  cache_geom_pkg::tag_t       victim_tag_i,
    input  logic                       victim_dirty_i,
    // Line merge
    output cache_geom_pkg::line_t      merge_line_o,
    output cache_geom_pkg::word_idx_t  merge_idx_o,
    output cache_geom_pkg::byte_en_t   merge_be_o,
    output cache_geom_pkg::word_t      merge_word_o,
    input  cache_geom_pkg::word_t      merge_rword_i,
    input  cache_geom_pkg::line_t      merged_line_i
);
    import cache_geom_pkg::*;
    import cache_ctrl_pkg::*;

    ctrl_state_e      state_q;
    ctrl_state_e      state_d;
    cpu_req_t         req_q;             // Request held while busy
    line_t            fill_q;            // Line from memory
    logic [WAY_W-1:0] fifo_q [N_SETS];   // Next victim per set
    cache_addr_u      cur_addr;
    cache_addr_u      wb_addr;
    cache_addr_u      fill_addr;
    logic             hit;

    assign hit = |hit_way_i;

    // ==============================
    // FSM
    // ==============================
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            state_q <= ST_IDLE;
        else
            state_q <= state_d;
    end

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            ST_IDLE:      if (p_req_i) state_d = ST_LOOKUP;
            ST_LOOKUP:
            begin
                if (hit)
                    state_d = ST_IDLE;
                else
                    state_d = victim_dirty_i ? ST_WB : ST_FILL;   // Clean victim skips WB
            end
            ST_WB:        if (m_ready_i) state_d = ST_WB_DONE;
            ST_WB_DONE:   state_d = ST_FILL;
            ST_FILL:      if (m_ready_i) state_d = ST_FILL_DONE;
            ST_FILL_DONE: state_d = ST_IDLE;
            default:      state_d = ST_IDLE;
        endcase
    end

    // Request capture follows the bus until accepted
    always_ff @(posedge clk_i)
    begin
        if (state_q == ST_IDLE)
            req_q <= p_cpu_req_i;
    end

    // Fill line register
    always_ff @(posedge clk_i)
    begin
        if (state_q == ST_FILL && m_ready_i)
            fill_q <= m_rdata_i;
    end

    // Array index from the bus in idle so the read is ready in lookup
    assign cur_addr = (state_q == ST_IDLE) ? p_cpu_req_i.addr : req_q.addr;
    assign set_o    = cur_addr.f.set;
    assign tag_o    = cur_addr.f.tag;

    // ==============================
    // FIFO replacement
    // ==============================
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            for (int s = 0; s < N_SETS; s++)
                fifo_q[s] <= '0;
        end
        else if (state_q == ST_FILL_DONE)
        begin
            fifo_q[set_o] <= fifo_q[set_o] + 1'b1;   // Wraps at N_WAYS
        end
    end

    assign victim_way_o = fifo_q[set_o];

    // ==============================
    // Array writes
    // ==============================
    always_comb
    begin
        wr_way_o = '0;
        if (state_q == ST_LOOKUP && hit && req_q.rw)
            wr_way_o = hit_way_i;                    // Write hit
        else if (state_q == ST_FILL_DONE)
            wr_way_o[victim_way_o] = 1'b1;           // Refill the victim
    end

    assign wr_line_o   = req_q.rw ? merged_line_i : fill_q;   // Reads store the raw fill
    assign valid_set_o = (state_q == ST_FILL_DONE);
    assign dirty_set_o = req_q.rw && ((state_q == ST_LOOKUP && hit) || state_q == ST_FILL_DONE);
    assign dirty_clr_o = (state_q == ST_WB_DONE);  // Victim now clean in memory

    // Merge source
    assign merge_line_o = (state_q == ST_FILL_DONE) ? fill_q : hit_line_i;
    assign merge_idx_o  = req_q.addr.f.word;
    assign merge_be_o   = req_q.byte_en;
    assign merge_word_o = req_q.wdata;

    // ==============================
    // Processor and memory outputs
    // ==============================
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            p_ready_o <= 1'b0;
            p_rdata_o <= '0;
        end
        else
        begin
            p_ready_o <= (state_q == ST_LOOKUP && hit) || state_q == ST_FILL_DONE;
            if (((state_q == ST_LOOKUP && hit) || state_q == ST_FILL_DONE) && !req_q.rw)
                p_rdata_o <= merge_rword_i;
            else
                p_rdata_o <= '0;
        end
    end

    always_comb
    begin
        wb_addr            = '0;
        wb_addr.f.tag      = victim_tag_i;   // Victim line address
        wb_addr.f.set      = req_q.addr.f.set;
        fill_addr          = req_q.addr;
        fill_addr.l.offset = '0;             // Line aligned fetch
    end

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            m_req_o.strobe <= 1'b0;
        else
            m_req_o.strobe <= (state_q == ST_WB || state_q == ST_FILL) && !m_ready_i;
        if (state_q == ST_WB)
        begin
            m_req_o.rw    <= 1'b1;
            m_req_o.addr  <= wb_addr;
            m_req_o.wdata <= victim_line_i;
        end
        else if (state_q == ST_FILL)
        begin
            m_req_o.rw   <= 1'b0;
            m_req_o.addr <= fill_addr;
        end
    end

    // Completion is a single pulse per request
    a_ready_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
        p_ready_o |=> !p_ready_o);

    // Memory traffic only while a miss is in progress
    a_no_strobe_idle: assert property (@(posedge clk_i) disable iff (rst_i)
        (state_q == ST_IDLE) |-> !m_req_o.strobe);

endmodule

`default_nettype wire

// File: src/dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_top
#(
    parameter int N_WAYS = 4
)
(
    input  logic                      clk_i,
    input  logic                      rst_i,
    // Processor
    input  logic                      p_req_i,
    input  cache_ctrl_pkg::cpu_req_t  p_cpu_req_i,
    output cache_geom_pkg::word_t     p_rdata_o,
    output logic                      p_ready_o,
    // Memory
    output cache_ctrl_pkg::mem_req_t  m_req_o,
    input  cache_geom_pkg::line_t     m_rdata_i,
    input  logic                      m_ready_i
);
    import cache_geom_pkg::*;

    localparam int WAY_W = $clog2(N_WAYS);

    // Controller <-> way store
    set_idx_t           set;
    tag_t               tag;
    logic [N_WAYS-1:0]  wr_way;
    line_t              wr_line;
    logic               valid_set;
    logic               dirty_set;
    logic               dirty_clr;
    logic [WAY_W-1:0]   victim_way;
    logic [N_WAYS-1:0]  hit_way;
    line_t              hit_line;
    line_t              victim_line;
    tag_t               victim_tag;
    logic               victim_dirty;

    // Controller <-> line merge
    line_t              merge_line;
    word_idx_t          merge_idx;
    byte_en_t           merge_be;
    word_t              merge_word;
    word_t              merge_rword;
    line_t              merged_line;

    dcache_ctrl #(.N_WAYS(N_WAYS)) u_ctrl (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .p_req_i        (p_req_i),
        .p_cpu_req_i    (p_cpu_req_i),
        .p_rdata_o      (p_rdata_o),
        .p_ready_o      (p_ready_o),
        .m_req_o        (m_req_o),
        .m_rdata_i      (m_rdata_i),
        .m_ready_i      (m_ready_i),
        .set_o          (set),
        .tag_o          (tag),
        .wr_way_o       (wr_way),
        .wr_line_o      (wr_line),
        .valid_set_o    (valid_set),
        .dirty_set_o    (dirty_set),
        .dirty_clr_o    (dirty_clr),
        .victim_way_o   (victim_way),
        .hit_way_i      (hit_way),
        .hit_line_i     (hit_line),
        .victim_line_i  (victim_line),
        .victim_tag_i   (victim_tag),
        .victim_dirty_i (victim_dirty),
        .merge_line_o   (merge_line),
        .merge_idx_o    (merge_idx),
        .merge_be_o     (merge_be),
        .merge_word_o   (merge_word),
        .merge_rword_i  (merge_rword),
        .merged_line_i  (merged_line)
    );

    way_store #(.N_WAYS(N_WAYS)) u_way_store (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .set_i          (set),
        .tag_i          (tag),
        .wr_way_i       (wr_way),
        .wr_line_i      (wr_line),
        .valid_set_i    (valid_set),
        .dirty_set_i    (dirty_set),
        .dirty_clr_i    (dirty_clr),
        .victim_way_i   (victim_way),
        .hit_way_o      (hit_way),
        .hit_line_o     (hit_line),
        .victim_tag_o   (victim_tag),
        .victim_line_o  (victim_line),
        .victim_dirty_o (victim_dirty)
    );

    line_merge u_line_merge (
        .line_i     (merge_line),
        .word_idx_i (merge_idx),
        .byte_en_i  (merge_be),
        .wdata_i    (merge_word),
        .rword_o    (merge_rword),
        .line_o     (merged_line)
    );

endmodule

`default_nettype wire

// File: verification/tb_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_model
(
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  cache_ctrl_pkg::mem_req_t  req_i,
    output cache_geom_pkg::line_t     rdata_o,
    output logic                      ready_o,
    output logic [31:0]               fill_cnt_o,   // Line reads served
    output logic [31:0]               wb_cnt_o,     // Write-backs taken
    output logic [31:0]               wb_addr_o,    // Last write-back address
    output cache_geom_pkg::line_t     wb_line_o     // Last write-back line
);
    import cache_geom_pkg::*;
    import cache_ctrl_pkg::*;

    localparam logic [31:0] SEED = 32'hefa2_759c;

    line_t       mem [logic [31:0]];   // Keyed by line address
    logic [31:0] wb_log [$];           // Every write-back address in order
    int          delay;

    // Each untouched word is its byte address XOR a marker
    function automatic line_t init_line(input logic [31:0] addr);
        line_t l;
        for (int w = 0; w < WORDS_PER_LINE; w++)
            l[LINE_W-1-w*WORD_W -: WORD_W] = (addr + 32'(4 * w)) ^ 32'h5a5a_0000;
        return l;
    endfunction

    // ==============================
    // Reply process
    // ==============================
    initial
    begin
        void'($urandom(SEED));   // Seeded once for the whole run
        ready_o    = 1'b0;
        rdata_o    = '0;
        fill_cnt_o = '0;
        wb_cnt_o   = '0;
        wb_addr_o  = '0;
        wb_line_o  = '0;
        forever
        begin
            @(negedge clk_i);
            if (!rst_i && req_i.strobe)
            begin
                delay = 1 + int'($urandom % 6);   // 1 to 6 cycles
                repeat (delay) @(negedge clk_i);
                if (req_i.rw)
                begin
                    mem[req_i.addr] = req_i.wdata;   // Write-back lands
                    wb_log.push_back(req_i.addr);
                    wb_cnt_o  = wb_cnt_o + 1;
                    wb_addr_o = wb_log[$];
                    wb_line_o = req_i.wdata;
                end
                else
                begin
                    rdata_o    = mem.exists(req_i.addr) ? mem[req_i.addr] : init_line(req_i.addr);
                    fill_cnt_o = fill_cnt_o + 1;
                end
                ready_o = 1'b1;   // One-cycle pulse
                @(negedge clk_i);
                ready_o = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: verification/tb_dcache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dcache;
    import cache_geom_pkg::*;
    import cache_ctrl_pkg::*;

    localparam int TIMEOUT = 100;   // Cycles allowed per wait

    logic        clk = 1'b0;
    logic        rst;
    logic        p_req;
    cpu_req_t    p_cpu_req;
    word_t       p_rdata;
    logic        p_ready;
    mem_req_t    m_req;
    line_t       m_rdata;
    logic        m_ready;
    logic [31:0] fill_cnt;
    logic [31:0] wb_cnt;
    logic [31:0] wb_addr;
    line_t       wb_line;

    string       test_name;
    word_t       ref_mem [logic [31:0]];   // Expected words by word address

    always #20 clk = ~clk;   // 40 ns period

    dcache_top #(.N_WAYS(4)) u_dut (
        .clk_i       (clk),
        .rst_i       (rst),
        .p_req_i     (p_req),
        .p_cpu_req_i (p_cpu_req),
        .p_rdata_o   (p_rdata),
        .p_ready_o   (p_ready),
        .m_req_o     (m_req),
        .m_rdata_i   (m_rdata),
        .m_ready_i   (m_ready)
    );

    tb_mem_model u_mem (
        .clk_i      (clk),
        .rst_i      (rst),
        .req_i      (m_req),
        .rdata_o    (m_rdata),
        .ready_o    (m_ready),
        .fill_cnt_o (fill_cnt),
        .wb_cnt_o   (wb_cnt),
        .wb_addr_o  (wb_addr),
        .wb_line_o  (wb_line)
    );

    // ==============================
    // Reference memory
    // ==============================
    function automatic word_t ref_read(input logic [31:0] addr);
        logic [31:0] a;
        a = {addr[31:2], 2'b00};
        if (ref_mem.exists(a))
            return ref_mem[a];
        else
            return a ^ 32'h5a5a_0000;   // Initial memory pattern
    endfunction

    task automatic ref_write(input logic [31:0] addr, input byte_en_t be, input word_t wdata);
        word_t w;
        w = ref_read(addr);
        for (int b = 0; b < 4; b++)
        begin
            if (be[b])
                w[b*8 +: 8] = wdata[b*8 +: 8];   // Enabled bytes only
        end
        ref_mem[{addr[31:2], 2'b00}] = w;
    endtask

    // ==============================
    // Checks and waits
    // ==============================
    task automatic check_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act)
        begin
            $display("ERR %s %s: expected %h, actual %h", test_name, what, exp, act);
            $display("Simulation FAILED");
            $fatal(1, "Value mismatch");
        end
    endtask

    // Counts falling edges since the request was driven
    task automatic wait_ready(output int cycles);
        cycles = 1;
        while (!p_ready)
        begin
            if (cycles >= TIMEOUT)
            begin
                $display("Simulation FAILED");
                $fatal(1, "Timed out waiting for the cache to answer in %s", test_name);
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    task automatic wait_strobe();
        int n;
        n = 0;
        while (!m_req.strobe)
        begin
            if (n >= TIMEOUT)
            begin
                $display("Simulation FAILED");
                $fatal(1, "Timed out waiting for a memory request in %s", test_name);
            end
            @(negedge clk);
            n++;
        end
    endtask

    // Request held stable while p_req pulses for one cycle
    task automatic issue(input logic rw, input logic [31:0] addr, input byte_en_t be,
                         input word_t wdata);
        p_cpu_req = {rw, be, addr, wdata};
        p_req     = 1'b1;
        @(negedge clk);
        p_req     = 1'b0;
    endtask

    task automatic read_word(input logic [31:0] addr, output int cycles);
        issue(1'b0, addr, 4'hf, '0);
        wait_ready(cycles);
        check_eq("read data", ref_read(addr), p_rdata);
    endtask

    task automatic write_word(input logic [31:0] addr, input byte_en_t be, input word_t wdata,
                              output int cycles);
        issue(1'b1, addr, be, wdata);
        wait_ready(cycles);
        check_eq("write p_rdata", 32'h0, p_rdata);   // No read word on a write
        ref_write(addr, be, wdata);
    endtask

    // ==============================
    // Directed tests
    // ==============================
    task automatic reset_state();
        test_name = "reset_state";
        check_eq("p_ready", 32'h0, 32'(p_ready));
        check_eq("mem strobe", 32'h0, 32'(m_req.strobe));
        check_eq("p_rdata", 32'h0, p_rdata);
    endtask

    task automatic cold_read_miss();
        int cycles;
        test_name = "cold_read_miss";
        issue(1'b0, 32'h0000_1044, 4'hf, '0);   // Set 2 word 1
        wait_strobe();
        check_eq("mem rw", 32'h0, 32'(m_req.rw));
        check_eq("mem addr", 32'h0000_1040, m_req.addr);
        wait_ready(cycles);
        check_eq("read data", ref_read(32'h0000_1044), p_rdata);
    endtask

    task automatic read_hit();
        int          cycles;
        logic [31:0] fills;
        logic [31:0] wbs;
        test_name = "read_hit";
        fills = fill_cnt;
        wbs   = wb_cnt;
        read_word(32'h0000_1050, cycles);
        check_eq("hit latency", 32'd2, cycles);
        check_eq("fill count", fills, fill_cnt);   // Memory untouched
        check_eq("write-back count", wbs, wb_cnt);
    endtask

    task automatic write_hit();
        int cycles;
        test_name = "write_hit";
        write_word(32'h0000_1048, 4'b0001, 32'haabb_ccdd, cycles);   // Single byte
        check_eq("write latency", 32'd2, cycles);
        write_word(32'h0000_104c, 4'b1100, 32'h1122_3344, cycles);   // Upper halfword
        check_eq("write latency", 32'd2, cycles);
        write_word(32'h0000_1054, 4'b1010, 32'hdead_beef, cycles);   // Mixed
        check_eq("write latency", 32'd2, cycles);
        read_word(32'h0000_1048, cycles);
        read_word(32'h0000_104c, cycles);
        read_word(32'h0000_1054, cycles);
        check_eq("read latency", 32'd2, cycles);
    endtask

    task automatic write_miss();
        int          cycles;
        logic [31:0] fills;
        test_name = "write_miss";
        fills = fill_cnt;
        write_word(32'h0000_2064, 4'b0110, 32'h0f0e_0d0c, cycles);   // Set 3 word 1
        check_eq("fill count", fills + 1, fill_cnt);
        read_word(32'h0000_2064, cycles);
        check_eq("read latency", 32'd2, cycles);
        read_word(32'h0000_2060, cycles);   // Neighbours unchanged
        read_word(32'h0000_207c, cycles);
    endtask

    task automatic fifo_eviction();
        int          cycles;
        logic [31:0] fills;
        logic [31:0] wbs;
        test_name = "fifo_eviction";
        wbs = wb_cnt;
        write_word(32'h0000_10a8, 4'hf, 32'h1234_5678, cycles);   // First fill of set 5
        read_word(32'h0000_12a0, cycles);
        read_word(32'h0000_14a0, cycles);
        read_word(32'h0000_16a0, cycles);   // Set now full
        check_eq("write-back count", wbs, wb_cnt);
        read_word(32'h0000_18a0, cycles);   // Evicts the first-filled way
        check_eq("write-back count", wbs + 1, wb_cnt);
        check_eq("write-back addr", 32'h0000_10a0, wb_addr);
        for (int w = 0; w < WORDS_PER_LINE; w++)
            check_eq("write-back data", ref_read(32'h0000_10a0 + 4 * w),
                     wb_line[LINE_W-1-w*WORD_W -: WORD_W]);
        fills = fill_cnt;
        read_word(32'h0000_10a8, cycles);   // Back from memory
        check_eq("refill count", fills + 1, fill_cnt);
    endtask

    // ==============================
    // Main sequence
    // ==============================
    initial
    begin
        rst       = 1'b1;
        p_req     = 1'b0;
        p_cpu_req = '0;
        repeat (5) @(negedge clk);
        rst = 1'b0;

        reset_state();
        cold_read_miss();
        read_hit();
        write_hit();
        write_miss();
        fifo_eviction();

        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
src/cache_geom_pkg.sv
src/cache_ctrl_pkg.sv
src/line_merge.sv
src/way_store.sv
src/dcache_ctrl.sv
src/dcache_top.sv
verification/tb_mem_model.sv
verification/tb_dcache.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the data cache testbench with Verilator and run it
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f tb.f --top-module tb_dcache -o sim_tb_dcache; then
    echo "Verilator build failed"
    exit 1
fi

if ! ./obj_dir/sim_tb_dcache; then
    echo "Simulation run failed"
    exit 1
fi

exit 0
